// ==== source/pcs_cfg.svh ====
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// capture address width, depth is 2**PCS_ADDR_NBIT
`define PCS_ADDR_NBIT 5

// one encoded block, sync header included
`define PCS_BLOCK_WIDTH 66

// block class as stored in the class memory
`define PCS_TYPE_WIDTH 4

// host register interface
`define PCS_HOST_ADDR_WIDTH 3
`define PCS_HOST_DATA_WIDTH 32

`endif

// ==== source/pcs_pkg.sv ====
`include "pcs_cfg.svh"

package pcs_pkg;

    // class of each encoded block
    typedef enum logic [`PCS_TYPE_WIDTH-1:0] {
        BLK_DATA  = 4'd0,
        BLK_IDLE  = 4'd1,
        BLK_START = 4'd2,
        BLK_TERM  = 4'd3,
        BLK_ERROR = 4'd4
    } block_class_e;

    // data view: sync header and eight data bytes
    typedef struct packed {
        logic [1:0]                    sync;
        logic [`PCS_BLOCK_WIDTH-3:0]   payload;
    } pcs_data_block_t;

    // control view: sync header, type byte and the rest of the block
    typedef struct packed {
        logic [1:0]                    sync;
        logic [7:0]                    block_type;
        logic [`PCS_BLOCK_WIDTH-11:0]  body;
    } pcs_ctrl_block_t;

    typedef union packed {
        pcs_data_block_t data;
        pcs_ctrl_block_t ctrl;
    } pcs_block_u;

    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // block type field values
    localparam logic [7:0] BT_IDLE   = 8'h1E;
    localparam logic [7:0] BT_START0 = 8'h78;
    localparam logic [7:0] BT_TERM0  = 8'h87;
    localparam logic [7:0] BT_TERM1  = 8'h99;
    localparam logic [7:0] BT_TERM2  = 8'hAA;
    localparam logic [7:0] BT_TERM3  = 8'hB4;
    localparam logic [7:0] BT_TERM4  = 8'hCC;
    localparam logic [7:0] BT_TERM5  = 8'hD2;
    localparam logic [7:0] BT_TERM6  = 8'hE1;
    localparam logic [7:0] BT_TERM7  = 8'hFF;

    // 7-bit control codes inside a control block
    localparam logic [6:0] CTL_IDLE  = 7'h00;
    localparam logic [6:0] CTL_ERROR = 7'h1E;

    // xgmii control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;

    // host register map
    localparam logic [`PCS_HOST_ADDR_WIDTH-1:0] REG_CONTROL   = 3'd0;
    localparam logic [`PCS_HOST_ADDR_WIDTH-1:0] REG_STATUS    = 3'd1;
    localparam logic [`PCS_HOST_ADDR_WIDTH-1:0] REG_READ_ADDR = 3'd2;
    localparam logic [`PCS_HOST_ADDR_WIDTH-1:0] REG_DATA_LO   = 3'd3;
    localparam logic [`PCS_HOST_ADDR_WIDTH-1:0] REG_DATA_MID  = 3'd4;
    localparam logic [`PCS_HOST_ADDR_WIDTH-1:0] REG_DATA_HI   = 3'd5;

endpackage

// ==== source/pcs_encoder_66b.sv ====
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_encoder_66b
(
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic [`PCS_BLOCK_WIDTH-3:0]  i_xgmii_data,
    input  logic [7:0]                   i_xgmii_ctrl,
    output pcs_pkg::pcs_block_u          o_block,
    output pcs_pkg::block_class_e        o_block_class
);

    import pcs_pkg::*;

    logic [7:0]    lane_idle;
    logic          all_idle;
    logic          start_lane0;
    logic          term_found;
    logic [2:0]    term_lane;
    logic [7:0]    term_type;
    logic [55:0]   term_mask;
    pcs_block_u    next_block;
    block_class_e  next_class;

    // a lane is idle when its control bit is set and it carries the idle character
    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            lane_idle[i] = i_xgmii_ctrl[i] && (i_xgmii_data[8*i +: 8] == XGMII_IDLE);
        end
    end

    assign all_idle    = &lane_idle;
    assign start_lane0 = (i_xgmii_ctrl == 8'h01) && (i_xgmii_data[7:0] == XGMII_START);

    // terminate in lane k needs data below it and idle in every lane above it
    always_comb
    begin
        term_found = 1'b0;
        term_lane  = 3'd0;
        for (int k = 0; k < 8; k++)
        begin
            if ((i_xgmii_ctrl == (8'hFF << k))
                && (i_xgmii_data[8*k +: 8] == XGMII_TERM)
                && ((lane_idle & (8'hFE << k)) == (8'hFE << k)))
            begin
                term_found = 1'b1;
                term_lane  = 3'(k);
            end
        end
    end

    always_comb
    begin
        case (term_lane)
            3'd0:    term_type = BT_TERM0;
            3'd1:    term_type = BT_TERM1;
            3'd2:    term_type = BT_TERM2;
            3'd3:    term_type = BT_TERM3;
            3'd4:    term_type = BT_TERM4;
            3'd5:    term_type = BT_TERM5;
            3'd6:    term_type = BT_TERM6;
            default: term_type = BT_TERM7;
        endcase
    end

    // keeps the data bytes in front of the terminate, zero codes after them
    assign term_mask = ~({56{1'b1}} << (8 * term_lane));

    always_comb
    begin
        next_block = '0;
        next_class = BLK_ERROR;
        if (i_xgmii_ctrl == 8'h00)
        begin
            next_block.data.sync    = SYNC_DATA;
            next_block.data.payload = i_xgmii_data;
            next_class              = BLK_DATA;
        end
        else
        begin
            next_block.ctrl.sync = SYNC_CTRL;
            if (all_idle)
            begin
                next_block.ctrl.block_type = BT_IDLE;
                next_block.ctrl.body       = {8{CTL_IDLE}};
                next_class                 = BLK_IDLE;
            end
            else if (start_lane0)
            begin
                // lane 0 holds the start, lanes 1 to 7 go through as data
                next_block.ctrl.block_type = BT_START0;
                next_block.ctrl.body       = i_xgmii_data[63:8];
                next_class                 = BLK_START;
            end
            else if (term_found)
            begin
                next_block.ctrl.block_type = term_type;
                next_block.ctrl.body       = i_xgmii_data[55:0] & term_mask;
                next_class                 = BLK_TERM;
            end
            else
            begin
                next_block.ctrl.block_type = BT_IDLE;
                next_block.ctrl.body       = {8{CTL_ERROR}};
                next_class                 = BLK_ERROR;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_block       <= '0;
            o_block_class <= BLK_DATA;
        end
        else
        begin
            o_block       <= next_block;
            o_block_class <= next_class;
        end
    end

    // the first block after reset is the first one that must carry a legal header
    a_sync_header_legal: assert property (
        @(posedge i_clock) disable iff (i_reset)
        1'b1 |=> ((o_block.data.sync == SYNC_DATA) || (o_block.data.sync == SYNC_CTRL))
    );

endmodule

// ==== source/capture_bram.sv ====
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module capture_bram
#(
    parameter int WIDTH = `PCS_BLOCK_WIDTH
)
(
    input  logic                       i_clock,
    input  logic                       i_write_enable,
    input  logic [`PCS_ADDR_NBIT-1:0]  i_write_addr,
    input  logic                       i_read_enable,
    input  logic [`PCS_ADDR_NBIT-1:0]  i_read_addr,
    input  logic [WIDTH-1:0]           i_data,
    output logic [WIDTH-1:0]           o_data
);

    localparam int DEPTH = 2 ** `PCS_ADDR_NBIT;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge i_clock)
    begin
        if (i_write_enable)
        begin
            mem[i_write_addr] <= i_data;
        end
        // registered read, one cycle of latency
        if (i_read_enable)
        begin
            o_data <= mem[i_read_addr];
        end
    end

    a_write_addr_known: assert property (
        @(posedge i_clock) i_write_enable |-> !$isunknown(i_write_addr)
    );

endmodule

// ==== source/capture_control.sv ====
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module capture_control
(
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_run,
    input  logic                       i_read,
    input  logic [`PCS_ADDR_NBIT-1:0]  i_read_addr,
    output logic                       o_write_enable,
    output logic [`PCS_ADDR_NBIT-1:0]  o_write_addr,
    output logic                       o_read_enable,
    output logic [`PCS_ADDR_NBIT-1:0]  o_read_addr,
    output logic                       o_full,
    output logic                       o_read_done
);

    import pcs_pkg::*;

    logic                      run_q;
    logic                      run_edge;
    logic                      capturing;
    // one extra bit so the count can reach the depth itself
    logic [`PCS_ADDR_NBIT:0]   addr_count;

    assign run_edge = i_run && !run_q;

    // both memories share this write port
    assign o_write_enable = capturing && !addr_count[`PCS_ADDR_NBIT];
    assign o_write_addr   = addr_count[`PCS_ADDR_NBIT-1:0];

    // host reads only reach the memories once the capture is complete
    assign o_read_enable = i_read && o_full;
    assign o_read_addr   = i_read_addr;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            run_q       <= 1'b0;
            capturing   <= 1'b0;
            addr_count  <= '0;
            o_full      <= 1'b0;
            o_read_done <= 1'b0;
        end
        else
        begin
            run_q       <= i_run;
            o_read_done <= o_read_enable;

            if (run_edge)
            begin
                // a new rising edge restarts the capture, even mid-run
                addr_count <= '0;
                capturing  <= 1'b1;
                o_full     <= 1'b0;
            end
            else if (capturing)
            begin
                if (addr_count[`PCS_ADDR_NBIT])
                begin
                    capturing <= 1'b0;
                    o_full    <= 1'b1;
                end
                else
                begin
                    addr_count <= addr_count + 1'b1;
                end
            end
        end
    end

    a_no_write_when_full: assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_full |-> !o_write_enable
    );

endmodule

// ==== source/capture_regs.sv ====
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module capture_regs
(
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_host_write,
    input  logic                             i_host_read,
    input  logic [`PCS_HOST_ADDR_WIDTH-1:0]  i_host_addr,
    input  logic [`PCS_HOST_DATA_WIDTH-1:0]  i_host_wdata,
    input  logic                             i_full,
    input  logic                             i_read_done,
    input  logic [`PCS_BLOCK_WIDTH-1:0]      i_block,
    input  logic [`PCS_TYPE_WIDTH-1:0]       i_block_class,
    output logic [`PCS_HOST_DATA_WIDTH-1:0]  o_host_rdata,
    output logic                             o_run,
    output logic                             o_read,
    output logic [`PCS_ADDR_NBIT-1:0]        o_read_addr
);

    import pcs_pkg::*;

    logic                             read_valid;
    logic [`PCS_BLOCK_WIDTH-1:0]      data_block;
    logic [`PCS_TYPE_WIDTH-1:0]       data_class;
    logic [`PCS_HOST_DATA_WIDTH-1:0]  rdata_mux;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_run       <= 1'b0;
            o_read      <= 1'b0;
            o_read_addr <= '0;
            read_valid  <= 1'b0;
        end
        else
        begin
            o_read <= 1'b0;
            if (i_read_done)
            begin
                read_valid <= 1'b1;
            end
            // a new read address launches a read and drops the old result
            if (i_host_write)
            begin
                case (i_host_addr)
                    REG_CONTROL:
                    begin
                        o_run <= i_host_wdata[0];
                    end
                    REG_READ_ADDR:
                    begin
                        o_read_addr <= i_host_wdata[`PCS_ADDR_NBIT-1:0];
                        o_read      <= 1'b1;
                        read_valid  <= 1'b0;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // memory words arrive together with read done
    always_ff @(posedge i_clock)
    begin
        if (i_read_done)
        begin
            data_block <= i_block;
            data_class <= i_block_class;
        end
    end

    always_comb
    begin
        rdata_mux = '0;
        case (i_host_addr)
            REG_CONTROL:   rdata_mux[0] = o_run;
            REG_STATUS:    rdata_mux[1:0] = {read_valid, i_full};
            REG_READ_ADDR: rdata_mux[`PCS_ADDR_NBIT-1:0] = o_read_addr;
            REG_DATA_LO:   rdata_mux = data_block[31:0];
            REG_DATA_MID:  rdata_mux = data_block[63:32];
            REG_DATA_HI:
            begin
                rdata_mux[1:0] = data_block[65:64];
                rdata_mux[7:4] = data_class;
            end
            default:       rdata_mux = '0;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_host_rdata <= '0;
        end
        else if (i_host_read)
        begin
            o_host_rdata <= rdata_mux;
        end
    end

endmodule

// ==== source/pcs_capture_top.sv ====
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module pcs_capture_top
(
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic [`PCS_BLOCK_WIDTH-3:0]      i_xgmii_data,
    input  logic [7:0]                       i_xgmii_ctrl,
    output pcs_pkg::pcs_block_u              o_block,
    output pcs_pkg::block_class_e            o_block_class,
    input  logic                             i_host_write,
    input  logic                             i_host_read,
    input  logic [`PCS_HOST_ADDR_WIDTH-1:0]  i_host_addr,
    input  logic [`PCS_HOST_DATA_WIDTH-1:0]  i_host_wdata,
    output logic [`PCS_HOST_DATA_WIDTH-1:0]  o_host_rdata
);

    import pcs_pkg::*;

    logic                            run;
    logic                            read;
    logic [`PCS_ADDR_NBIT-1:0]       read_addr;
    logic                            write_enable;
    logic [`PCS_ADDR_NBIT-1:0]       write_addr;
    logic                            read_enable;
    logic [`PCS_ADDR_NBIT-1:0]       ram_read_addr;
    logic                            full;
    logic                            read_done;
    logic [`PCS_BLOCK_WIDTH-1:0]     ram_block;
    logic [`PCS_TYPE_WIDTH-1:0]      ram_class;

    pcs_encoder_66b u_encoder (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_xgmii_data  (i_xgmii_data),
        .i_xgmii_ctrl  (i_xgmii_ctrl),
        .o_block       (o_block),
        .o_block_class (o_block_class)
    );

    capture_control u_control (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_run          (run),
        .i_read         (read),
        .i_read_addr    (read_addr),
        .o_write_enable (write_enable),
        .o_write_addr   (write_addr),
        .o_read_enable  (read_enable),
        .o_read_addr    (ram_read_addr),
        .o_full         (full),
        .o_read_done    (read_done)
    );

    // same control drives both memories
    capture_bram #(.WIDTH(`PCS_BLOCK_WIDTH)) u_block_ram (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (write_addr),
        .i_read_enable  (read_enable),
        .i_read_addr    (ram_read_addr),
        .i_data         (o_block),
        .o_data         (ram_block)
    );

    capture_bram #(.WIDTH(`PCS_TYPE_WIDTH)) u_class_ram (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (write_addr),
        .i_read_enable  (read_enable),
        .i_read_addr    (ram_read_addr),
        .i_data         (o_block_class),
        .o_data         (ram_class)
    );

    capture_regs u_regs (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_host_write  (i_host_write),
        .i_host_read   (i_host_read),
        .i_host_addr   (i_host_addr),
        .i_host_wdata  (i_host_wdata),
        .i_full        (full),
        .i_read_done   (read_done),
        .i_block       (ram_block),
        .i_block_class (ram_class),
        .o_host_rdata  (o_host_rdata),
        .o_run         (run),
        .o_read        (read),
        .o_read_addr   (read_addr)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);

    initial
    begin
        o_clock = 1'b0;
        forever
        begin
            #2 o_clock = ~o_clock;
        end
    end

    // reset held for two rising edges
    initial
    begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

// ==== testbench/tb_pcs_capture.sv ====
`timescale 1ns/1ps
`include "pcs_cfg.svh"

module tb_pcs_capture;

    import pcs_pkg::*;

    localparam int DEPTH = 2 ** `PCS_ADDR_NBIT;
    localparam int NUM_PASSES = 2;
    // one address read-back stays well under 40 cycles
    localparam int WATCHDOG_CYCLES = NUM_PASSES * DEPTH * 40 + 200;

    logic         i_clock;
    logic         i_reset;
    logic [63:0]  i_xgmii_data;
    logic [7:0]   i_xgmii_ctrl;
    logic [65:0]  o_block;
    logic [3:0]   o_block_class;
    logic         i_host_write;
    logic         i_host_read;
    logic [2:0]   i_host_addr;
    logic [31:0]  i_host_wdata;
    logic [31:0]  o_host_rdata;

    logic [69:0]  exp_q;
    logic         out_of_reset_q;
    logic [7:0]   wait_count;
    logic [69:0]  history [$];
    logic [69:0]  captured [DEPTH];

    tb_clock_gen u_clock_gen (
        .o_clock (i_clock),
        .o_reset (i_reset)
    );

    pcs_capture_top u_dut (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_xgmii_data  (i_xgmii_data),
        .i_xgmii_ctrl  (i_xgmii_ctrl),
        .o_block       (o_block),
        .o_block_class (o_block_class),
        .i_host_write  (i_host_write),
        .i_host_read   (i_host_read),
        .i_host_addr   (i_host_addr),
        .i_host_wdata  (i_host_wdata),
        .o_host_rdata  (o_host_rdata)
    );

    task automatic fail_value(input string name, input logic [69:0] got, input logic [69:0] exp);
        $display("Error: %s got %h expected %h", name, got, exp);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // reference 64b/66b rules, result is {class, block}
    function automatic logic [69:0] encode_word(input logic [63:0] d, input logic [7:0] c);
        logic [7:0]  term_types [8];
        logic [55:0] body;
        logic        ok;
        term_types = '{8'h87, 8'h99, 8'hAA, 8'hB4, 8'hCC, 8'hD2, 8'hE1, 8'hFF};
        if (c == 8'h00)
        begin
            return {4'd0, 2'b01, d};
        end
        if (c == 8'hFF && d == {8{8'h07}})
        begin
            return {4'd1, 2'b10, 8'h1E, 56'd0};
        end
        if (c == 8'h01 && d[7:0] == 8'hFB)
        begin
            return {4'd2, 2'b10, 8'h78, d[63:8]};
        end
        for (int k = 0; k < 8; k++)
        begin
            ok = (c == 8'(8'hFF << k)) && (d[8*k +: 8] == 8'hFD);
            body = '0;
            for (int j = 0; j < 8; j++)
            begin
                if (j > k && d[8*j +: 8] != 8'h07)
                begin
                    ok = 1'b0;
                end
                if (j < k)
                begin
                    body[8*j +: 8] = d[8*j +: 8];
                end
            end
            if (ok)
            begin
                return {4'd3, 2'b10, term_types[k], body};
            end
        end
        return {4'd4, 2'b10, 8'h1E, {8{7'h1E}}};
    endfunction

    always @(posedge i_clock)
    begin
        exp_q          <= encode_word(i_xgmii_data, i_xgmii_ctrl);
        out_of_reset_q <= !i_reset;
        if (out_of_reset_q && !i_reset)
        begin
            history.push_back({o_block_class, o_block});
        end
        if (i_reset || u_dut.full || !u_dut.run)
        begin
            wait_count <= '0;
        end
        else
        begin
            wait_count <= wait_count + 1'b1;
        end
    end

    a_block_encoding: assert property (@(posedge i_clock) disable iff (i_reset)
        out_of_reset_q |-> ({o_block_class, o_block} == exp_q))
        else fail_value("o_block_class,o_block", $sampled({o_block_class, o_block}),
                        $sampled(exp_q));

    a_full_clear_after_reset: assert property (@(posedge i_clock)
        $fell(i_reset) |-> !u_dut.full)
        else fail_text("full flag set right after reset");

    a_full_reached: assert property (@(posedge i_clock) disable iff (i_reset)
        wait_count <= 8'd40)
        else fail_text("full flag not set within 40 cycles of run");

    // the cycle in which run rises again belongs to the restart, not to the hold
    a_full_held: assert property (@(posedge i_clock) disable iff (i_reset)
        (u_dut.full && u_dut.run && $past(u_dut.run)) |=> u_dut.full)
        else fail_text("full flag dropped while run stayed high");

    a_full_cleared_on_edge: assert property (@(posedge i_clock) disable iff (i_reset)
        $rose(u_dut.run) |=> !u_dut.full)
        else fail_text("full flag not cleared by a new run edge");

    a_no_read_before_full: assert property (@(posedge i_clock) disable iff (i_reset)
        (u_dut.read && !u_dut.full) |=> !u_dut.read_done)
        else fail_text("read accepted while capture was not full");

    // random xgmii stream, mostly data so the capture window is unique
    initial
    begin
        logic [63:0] d;
        logic [7:0]  c;
        int          k;
        void'($urandom(70186));
        i_xgmii_data = '0;
        i_xgmii_ctrl = '0;
        forever
        begin
            @(posedge i_clock);
            d = {$urandom, $urandom};
            k = $urandom % 8;
            case ($urandom % 8)
                4:
                begin
                    c = 8'hFF;
                    d = {8{8'h07}};
                end
                5:
                begin
                    c = 8'h01;
                    d[7:0] = 8'hFB;
                end
                6:
                begin
                    c = 8'(8'hFF << k);
                    d[8*k +: 8] = 8'hFD;
                    for (int j = k + 1; j < 8; j++)
                    begin
                        d[8*j +: 8] = 8'h07;
                    end
                end
                7: c = 8'($urandom % 255 + 1);
                default: c = 8'h00;
            endcase
            i_xgmii_data <= d;
            i_xgmii_ctrl <= c;
        end
    end

    task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
        @(posedge i_clock);
        i_host_write <= 1'b1;
        i_host_addr  <= addr;
        i_host_wdata <= data;
        @(posedge i_clock);
        i_host_write <= 1'b0;
    endtask

    task automatic host_read(input logic [2:0] addr, output logic [31:0] data);
        @(posedge i_clock);
        i_host_read <= 1'b1;
        i_host_addr <= addr;
        @(posedge i_clock);
        i_host_read <= 1'b0;
        @(posedge i_clock);
        data = o_host_rdata;
    endtask

    task automatic wait_full();
        logic [31:0] status;
        int          tries;
        tries = 0;
        do
        begin
            host_read(REG_STATUS, status);
            tries++;
            if (tries > 60)
            begin
                fail_text("capture never reported full");
            end
        end
        while (!status[0]);
    endtask

    task automatic read_back_and_check();
        logic [31:0] lo;
        logic [31:0] mid;
        logic [31:0] hi;
        logic [31:0] status;
        int          tries;
        bit          found;
        bit          same;
        for (int a = 0; a < DEPTH; a++)
        begin
            host_write(REG_READ_ADDR, a);
            tries = 0;
            do
            begin
                host_read(REG_STATUS, status);
                tries++;
                if (tries > 10)
                begin
                    fail_text("read valid never set after a read");
                end
            end
            while (!status[1]);
            host_read(REG_DATA_LO, lo);
            host_read(REG_DATA_MID, mid);
            host_read(REG_DATA_HI, hi);
            captured[a] = {hi[7:4], hi[1:0], mid, lo};
        end
        // the capture must match one window of the line history
        found = 1'b0;
        for (int s = 0; s + DEPTH <= history.size(); s++)
        begin
            same = 1'b1;
            for (int a = 0; a < DEPTH; a++)
            begin
                if (history[s + a] != captured[a])
                begin
                    same = 1'b0;
                end
            end
            if (same)
            begin
                found = 1'b1;
            end
        end
        assert (found) else fail_text("captured blocks are not a contiguous run of the stream");
    endtask

    initial
    begin
        logic [31:0] status;
        i_host_write = 1'b0;
        i_host_read  = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        @(negedge i_reset);

        // read attempt before any capture
        host_write(REG_READ_ADDR, 32'd3);
        // an accepted read would have reached read valid after these two cycles
        repeat (2) @(posedge i_clock);
        host_read(REG_STATUS, status);
        assert (status[1:0] == 2'b00)
            else fail_value("o_host_rdata", {38'd0, status}, 70'h0);

        for (int p = 0; p < NUM_PASSES; p++)
        begin
            host_write(REG_CONTROL, 32'd0);
            host_write(REG_CONTROL, 32'd1);
            wait_full();
            read_back_and_check();
        end

        $display("Done: no errors");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        fail_text("timeout, the test did not finish in time");
    end

endmodule

// ==== files.f ====
+incdir+source
source/pcs_pkg.sv
source/pcs_encoder_66b.sv
source/capture_bram.sv
source/capture_control.sv
source/capture_regs.sv
source/pcs_capture_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pcs_capture.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_pcs_capture \
    -f files.f

./obj_dir/Vtb_pcs_capture | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
